//--- all.f
hdl/rv_pkg.sv
hdl/id_ex_if.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/rv32_core.sv
test/tb_rv32_core.sv

//--- Makefile
# Verilator simulation of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv32_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_rv32_core.sv
`timescale 1ns/1ns

module tb_rv32_core
    import rv_pkg::*;
();

    localparam int CLK_PERIOD     = 10;
    localparam int WB_TEST_CYCLES = 32 * 4;
    localparam int MAX_PROG_WORDS = 64;
    localparam int RUN_CYCLES     = 200;
    // reset, load at four cycles a word, run, settle
    localparam int PROG_CYCLES    = 4 * MAX_PROG_WORDS + RUN_CYCLES + 16;
    localparam int PROG_RUNS      = 7;
    localparam int TOTAL_CYCLES   = 2 + WB_TEST_CYCLES + PROG_RUNS * PROG_CYCLES + 100;

    logic               clk;
    logic               rst_n;
    logic               run;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [IMEM_AW-1:0] wb_adr;
    logic [XLEN-1:0]    wb_dat_w;
    logic [XLEN-1:0]    wb_dat_r;
    logic               wb_ack;
    logic [XLEN-1:0]    pc;
    logic               retire_valid;
    logic [REG_AW-1:0]  retire_rd;
    logic [XLEN-1:0]    retire_data;

    // program image and expected retire stream
    logic [31:0] prog [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    // observed retire stream
    logic [4:0]  ret_rd [$];
    logic [31:0] ret_data [$];
    // register model used while building programs
    logic [31:0] ref_regs [32];
    logic [31:0] rng_state;

    rv32_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .pc           (pc),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", TOTAL_CYCLES);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // retire monitor, mid cycle so values are settled
    always @(negedge clk) begin
        if (rst_n && retire_valid) begin
            ret_rd.push_back(retire_rd);
            ret_data.push_back(retire_data);
        end
    end

    // ------------------------------------------------------------------
    // random numbers, reference rules, encoders
    // ------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // signed 12-bit immediate
    function automatic int rand_imm();
        logic [31:0] r;
        r = next_random();
        return int'($signed(r[11:0]));
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            F3_ADD:  return sub ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_SRL:  return a >> b[4:0];
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            default: return $signed(a) >= $signed(b);
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic sub, input logic [2:0] f3, input int rd,
                                          input int rs1, input int rs2);
        return {sub ? 7'b0100000 : 7'b0000000, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd, input int rs1,
                                          input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), OP_IMM};
    endfunction

    // offset bits imm[12|10:5] rs2 rs1 f3 imm[4:1|11]
    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input int rs1,
                                               input int rs2, input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], OP_BRANCH};
    endfunction

    // offset bits imm[20|10:1|11|19:12]
    function automatic logic [31:0] enc_jal(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OP_JAL};
    endfunction

    // ------------------------------------------------------------------
    // program building, model tracks every register write
    // ------------------------------------------------------------------
    task automatic new_program();
        prog.delete();
        exp_rd.delete();
        exp_data.delete();
        foreach (ref_regs[i])
            ref_regs[i] = '0;
    endtask

    // x0 writes never retire
    task automatic expect_write(input int rd, input logic [31:0] value);
        if (rd != 0) begin
            ref_regs[rd] = value;
            exp_rd.push_back(5'(rd));
            exp_data.push_back(value);
        end
    endtask

    task automatic emit_r(input logic sub, input logic [2:0] f3, input int rd, input int rs1,
                          input int rs2);
        prog.push_back(enc_r(sub, f3, rd, rs1, rs2));
        expect_write(rd, alu_model(f3, sub, ref_regs[rs1], ref_regs[rs2]));
    endtask

    task automatic emit_i(input logic [2:0] f3, input int rd, input int rs1, input int imm);
        prog.push_back(enc_i(f3, rd, rs1, imm));
        expect_write(rd, alu_model(f3, 1'b0, ref_regs[rs1], 32'(imm)));
    endtask

    task automatic emit_lui(input int rd, input logic [19:0] imm20);
        prog.push_back({imm20, 5'(rd), OP_LUI});
        expect_write(rd, {imm20, 12'h000});
    endtask

    // link is the address after the jal
    task automatic emit_jal(input int rd, input int off);
        logic [31:0] link;
        link = 32'(4 * prog.size() + 4);
        prog.push_back(enc_jal(rd, off));
        expect_write(rd, link);
    endtask

    // lui + addi, upper part rounded for the signed low half
    task automatic load_const(input int rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h0000_0800;
        emit_lui(rd, hi[31:12]);
        emit_i(F3_ADD, rd, rd, int'($signed(value[11:0])));
    endtask

    // jump to self
    task automatic halt();
        prog.push_back(enc_jal(0, 0));
    endtask

    // ------------------------------------------------------------------
    // bus, reset and run helpers
    // ------------------------------------------------------------------
    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // one classic cycle, ack expected on the second negedge
    task automatic wb_access(input logic we, input logic [IMEM_AW-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 8);
        check_equal(32'(waited), 32'd2, "wishbone ack latency");
        rdata = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_equal(32'(wb_ack), 32'd0, "wishbone ack length");
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        run   <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_program(input string name);
        logic [31:0] dummy;
        logic [31:0] halt_pc;
        logic [31:0] loop_ofs;
        int          cycles;
        pulse_reset();
        foreach (prog[i])
            wb_access(1'b1, IMEM_AW'(i), prog[i], dummy);
        // fetch parked at 0 while run is low
        check_equal(pc, 32'h0, {name, " pc while idle"});
        ret_rd.delete();
        ret_data.delete();
        @(posedge clk);
        run <= 1'b1;
        cycles = 0;
        while (ret_rd.size() < exp_rd.size() && cycles < RUN_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (ret_rd.size() < exp_rd.size()) begin
            $display("test %s saw only %0d of %0d retires within %0d cycles",
                     name, ret_rd.size(), exp_rd.size(), RUN_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "retire timeout");
        end
        // window for stray retires after the halt loop
        repeat (8) @(posedge clk);
        @(negedge clk);
        // halt jumps to itself, fetch cycles over it and the two flushed words
        halt_pc  = 32'(4 * (prog.size() - 1));
        loop_ofs = pc - halt_pc;
        check_equal(32'(loop_ofs == 32'd0 || loop_ofs == 32'd4 || loop_ofs == 32'd8), 32'd1,
                    {name, " pc in halt loop"});
        foreach (exp_rd[i]) begin
            check_equal(32'(ret_rd[i]), 32'(exp_rd[i]), $sformatf("%s retire %0d rd", name, i));
            check_equal(ret_data[i], exp_data[i], $sformatf("%s retire %0d data", name, i));
        end
        check_equal(32'(ret_rd.size()), 32'(exp_rd.size()), {name, " retire count"});
        @(posedge clk);
        run <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    task automatic test_wishbone();
        logic [31:0]        words [16];
        logic [31:0]        rd_word;
        logic [31:0]        r;
        logic [IMEM_AW-1:0] base;
        r = next_random();
        base = r[IMEM_AW-1:0];
        foreach (words[i]) begin
            words[i] = next_random();
            wb_access(1'b1, base + IMEM_AW'(i), words[i], rd_word);
        end
        foreach (words[i]) begin
            wb_access(1'b0, base + IMEM_AW'(i), 32'h0, rd_word);
            check_equal(rd_word, words[i], $sformatf("readback word %0d", i));
        end
    endtask

    task automatic test_alu();
        for (int n = 0; n < 3; n++) begin
            new_program();
            load_const(1, next_random());
            load_const(2, next_random());
            emit_r(1'b0, F3_ADD, 3, 1, 2);
            emit_r(1'b1, F3_ADD, 4, 1, 2);
            emit_r(1'b0, F3_AND, 5, 1, 2);
            emit_r(1'b0, F3_OR, 6, 1, 2);
            emit_r(1'b0, F3_XOR, 7, 1, 2);
            emit_r(1'b0, F3_SLT, 8, 1, 2);
            emit_r(1'b0, F3_SLT, 9, 2, 1);
            emit_r(1'b0, F3_SLL, 10, 1, 2);
            emit_r(1'b0, F3_SRL, 11, 1, 2);
            emit_i(F3_ADD, 12, 1, rand_imm());
            emit_i(F3_AND, 13, 1, rand_imm());
            emit_i(F3_OR, 14, 1, rand_imm());
            emit_i(F3_XOR, 15, 1, rand_imm());
            emit_i(F3_SLT, 16, 1, rand_imm());
            halt();
            run_program("alu");
        end
    endtask

    task automatic test_dependencies();
        new_program();
        load_const(1, next_random());
        // one back, served by forwarding
        for (int i = 2; i < 10; i++)
            emit_i(F3_ADD, i, i - 1, rand_imm());
        emit_r(1'b1, F3_ADD, 10, 9, 8);
        emit_r(1'b0, F3_XOR, 11, 10, 9);
        // two interleaved chains, two back goes through the register file
        emit_i(F3_ADD, 16, 0, rand_imm());
        emit_i(F3_ADD, 17, 0, rand_imm());
        for (int i = 18; i < 26; i++)
            emit_i(F3_ADD, i, i - 2, rand_imm());
        emit_r(1'b0, F3_ADD, 26, 24, 25);
        halt();
        run_program("dependencies");
    endtask

    task automatic test_branches();
        logic [2:0]  f3;
        logic [31:0] pos;
        logic [31:0] neg;
        logic [31:0] a;
        logic [31:0] b;
        logic [7:0]  a_pos;
        logic [7:0]  b_pos;
        // pairs per case, even cases taken, odd not taken
        a_pos = 8'b0110_1000;
        b_pos = 8'b1001_1110;
        new_program();
        for (int i = 0; i < 8; i++) begin
            pos = next_random() & 32'h7fff_ffff;
            neg = next_random() | 32'h8000_0000;
            case (i / 2)
                0:       f3 = F3_BEQ;
                1:       f3 = F3_BNE;
                2:       f3 = F3_BLT;
                default: f3 = F3_BGE;
            endcase
            a = a_pos[i] ? pos : neg;
            b = b_pos[i] ? pos : neg;
            load_const(1, a);
            load_const(2, b);
            // skips the two addi when taken
            prog.push_back(enc_branch(f3, 1, 2, 12));
            if (branch_model(f3, a, b)) begin
                prog.push_back(enc_i(F3_ADD, 3, 0, 100 + i));
                prog.push_back(enc_i(F3_ADD, 4, 0, 200 + i));
            end else begin
                emit_i(F3_ADD, 3, 0, 100 + i);
                emit_i(F3_ADD, 4, 0, 200 + i);
            end
        end
        emit_i(F3_ADD, 5, 0, 77);
        halt();
        run_program("branches");
    endtask

    task automatic test_jal();
        new_program();
        emit_i(F3_ADD, 1, 0, 5);
        emit_jal(2, 16);
        // jumped over, never retire
        prog.push_back(enc_i(F3_ADD, 3, 0, 1));
        prog.push_back(enc_i(F3_ADD, 4, 0, 2));
        prog.push_back(enc_i(F3_ADD, 5, 0, 3));
        // target, reads the link at once
        emit_r(1'b0, F3_ADD, 6, 2, 1);
        halt();
        run_program("jal");
    endtask

    task automatic test_x0();
        logic [31:0] r;
        new_program();
        r = next_random();
        emit_i(F3_ADD, 0, 0, 123);
        emit_lui(0, r[19:0]);
        load_const(7, next_random());
        emit_r(1'b0, F3_ADD, 0, 7, 7);
        emit_r(1'b0, F3_ADD, 8, 7, 0);
        emit_r(1'b0, F3_ADD, 9, 0, 7);
        emit_i(F3_ADD, 10, 0, 0);
        halt();
        run_program("x0");
    endtask

    initial begin
        rng_state = 32'd32995;
        rst_n     = 1'b0;
        run       = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_wishbone();
        test_alu();
        test_dependencies();
        test_branches();
        test_jal();
        test_x0();
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- hdl/rv32_core.sv
`timescale 1ns/1ns

module rv32_core
    import rv_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [IMEM_AW-1:0] wb_adr,
    input  logic [XLEN-1:0]    wb_dat_w,
    output logic [XLEN-1:0]    wb_dat_r,
    output logic               wb_ack,
    output logic [XLEN-1:0]    pc,
    output logic               retire_valid,
    output logic [REG_AW-1:0]  retire_rd,
    output logic [XLEN-1:0]    retire_data
);

    // ------------------------------------------------------------------
    // stage to stage wiring
    // ------------------------------------------------------------------
    logic              fd_valid;
    logic [XLEN-1:0]   fd_pc;
    instr_u            fd_instr;
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;
    // writeback triple, also the retire ports
    logic              wb_en;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;

    id_ex_if dx_if ();

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .pc          (pc),
        .fd_valid    (fd_valid),
        .fd_pc       (fd_pc),
        .fd_instr    (fd_instr)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .fd_valid (fd_valid),
        .fd_pc    (fd_pc),
        .fd_instr (fd_instr),
        .redirect (redirect),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .dx       (dx_if.producer)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .dx          (dx_if.consumer),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    // retire = register file write
    assign retire_valid = wb_en;
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_data;

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
    import rv_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    id_ex_if.consumer         dx,
    output logic              redirect,
    output logic [XLEN-1:0]   redirect_pc,
    output logic              wb_en,
    output logic [REG_AW-1:0] wb_rd,
    output logic [XLEN-1:0]   wb_data
);

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] result;
    logic            taken;

    // ------------------------------------------------------------------
    // forwarding from the retiring instruction
    // ------------------------------------------------------------------
    // wb_en is never set for x0
    assign rs1_fwd = (wb_en && wb_rd == dx.rs1_idx) ? wb_data : dx.rs1_val;
    assign rs2_fwd = (wb_en && wb_rd == dx.rs2_idx) ? wb_data : dx.rs2_val;
    assign alu_b   = dx.use_imm ? dx.imm : rs2_fwd;

    alu_unit u_alu (
        .op_a   (rs1_fwd),
        .op_b   (alu_b),
        .alu_op (dx.alu_op),
        .result (alu_result)
    );

    // compares registers, never the immediate
    branch_unit u_branch (
        .op_a      (rs1_fwd),
        .op_b      (rs2_fwd),
        .pc        (dx.pc),
        .imm       (dx.imm),
        .funct3    (dx.funct3),
        .is_branch (dx.is_branch),
        .is_jal    (dx.is_jal),
        .taken     (taken),
        .target    (redirect_pc)
    );

    // link address for jal
    assign result   = dx.is_jal ? dx.pc + XLEN'(4) : alu_result;
    assign redirect = dx.valid && taken;

    // ------------------------------------------------------------------
    // execute/writeback register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_en <= 1'b0;
        else
            wb_en <= dx.valid && dx.reg_write && dx.rd != '0;
    end

    always_ff @(posedge clk) begin
        wb_rd   <= dx.rd;
        wb_data <= result;
    end

    // pc and immediate both come in aligned
    a_redirect_align: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> redirect_pc[1:0] == 2'b00);

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
    import rv_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fd_valid,
    input  logic [XLEN-1:0]   fd_pc,
    input  instr_u            fd_instr,
    input  logic              redirect,
    input  logic              wb_en,
    input  logic [REG_AW-1:0] wb_rd,
    input  logic [XLEN-1:0]   wb_data,
    id_ex_if.producer         dx
);

    logic [XLEN-1:0] regs [0:(1 << REG_AW) - 1];
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            reg_write;
    logic            use_imm;
    logic            is_branch;
    logic            is_jal;
    alu_op_t         alu_op;

    // ------------------------------------------------------------------
    // immediates
    // ------------------------------------------------------------------
    assign imm_i = {{20{fd_instr.bi.hi_imm[11]}}, fd_instr.bi.hi_imm};
    // imm[12|10:5] in hi_imm[11:5], imm[4:1|11] in lo_imm
    assign imm_b = {{20{fd_instr.bi.hi_imm[11]}}, fd_instr.bi.lo_imm[0],
                    fd_instr.bi.hi_imm[10:5], fd_instr.bi.lo_imm[4:1], 1'b0};
    assign imm_u = {fd_instr.r.funct7, fd_instr.r.rs2, fd_instr.r.rs1,
                    fd_instr.r.funct3, 12'b0};
    // imm[20|10:1|11|19:12]
    assign imm_j = {{12{fd_instr.r.funct7[6]}}, fd_instr.r.rs1, fd_instr.r.funct3,
                    fd_instr.r.rs2[0], fd_instr.r.funct7[5:0], fd_instr.r.rs2[4:1],
                    1'b0};

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------
    always_comb begin
        reg_write = 1'b0;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        alu_op    = ALU_ADD;
        imm       = imm_i;
        case (fd_instr.r.opcode)
            OP_OP: begin
                reg_write = 1'b1;
                case (fd_instr.r.funct3)
                    // funct7 bit 5 selects sub
                    F3_ADD:  alu_op = fd_instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SRL:  alu_op = ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                case (fd_instr.bi.funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    // immediate shifts not supported
                    default: reg_write = 1'b0;
                endcase
            end
            OP_LUI: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = ALU_PASS_B;
                imm       = imm_u;
            end
            OP_BRANCH: begin
                imm = imm_b;
                case (fd_instr.bi.funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE: is_branch = 1'b1;
                    default:                        is_branch = 1'b0;
                endcase
            end
            OP_JAL: begin
                // link value formed in execute
                reg_write = 1'b1;
                is_jal    = 1'b1;
                imm       = imm_j;
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------
    // register file, write-through from writeback
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != '0)
            regs[wb_rd] <= wb_data;
    end

    always_comb begin
        if (fd_instr.r.rs1 == '0)
            rs1_val = '0;
        else if (wb_en && wb_rd == fd_instr.r.rs1)
            rs1_val = wb_data;
        else
            rs1_val = regs[fd_instr.r.rs1];
        if (fd_instr.r.rs2 == '0)
            rs2_val = '0;
        else if (wb_en && wb_rd == fd_instr.r.rs2)
            rs2_val = wb_data;
        else
            rs2_val = regs[fd_instr.r.rs2];
    end

    // ------------------------------------------------------------------
    // decode/execute register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dx.valid <= 1'b0;
        else
            dx.valid <= fd_valid && !redirect;
    end

    always_ff @(posedge clk) begin
        dx.pc        <= fd_pc;
        dx.rs1_idx   <= fd_instr.r.rs1;
        dx.rs2_idx   <= fd_instr.r.rs2;
        dx.rs1_val   <= rs1_val;
        dx.rs2_val   <= rs2_val;
        dx.imm       <= imm;
        dx.rd        <= fd_instr.r.rd;
        dx.reg_write <= reg_write;
        dx.use_imm   <= use_imm;
        dx.alu_op    <= alu_op;
        dx.is_branch <= is_branch;
        dx.is_jal    <= is_jal;
        dx.funct3    <= fd_instr.r.funct3;
    end

    // x0 never comes back as a writeback target, forwarded x0 stays zero
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> wb_rd != '0);

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
    import rv_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               redirect,
    input  logic [XLEN-1:0]    redirect_pc,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [IMEM_AW-1:0] wb_adr,
    input  logic [XLEN-1:0]    wb_dat_w,
    output logic [XLEN-1:0]    wb_dat_r,
    output logic               wb_ack,
    output logic [XLEN-1:0]    pc,
    output logic               fd_valid,
    output logic [XLEN-1:0]    fd_pc,
    output instr_u             fd_instr
);

    logic [XLEN-1:0]    imem [0:(1 << IMEM_AW) - 1];
    logic [IMEM_AW-1:0] fetch_idx;
    logic               wb_req;

    // word index, pc is byte addressed
    assign fetch_idx = pc[IMEM_AW+1:2];
    // new request, ack not yet given
    assign wb_req    = wb_cyc && wb_stb && !wb_ack;

    // ------------------------------------------------------------------
    // program counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else begin
            // held at 0 while the program is loaded
            if (!run)
                pc <= '0;
            else if (redirect)
                pc <= redirect_pc;
            else
                pc <= pc + XLEN'(4);
            // bubble while idle or on a taken branch
            fd_valid <= run && !redirect;
        end
    end

    // fetch/decode payload
    always_ff @(posedge clk) begin
        fd_pc    <= pc;
        fd_instr <= imem[fetch_idx];
    end

    // ------------------------------------------------------------------
    // wishbone load port
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_req;
    end

    always_ff @(posedge clk) begin
        // read data valid with ack
        if (wb_req)
            wb_dat_r <= imem[wb_adr];
        // write lands on the ack edge
        if (wb_ack && wb_cyc && wb_stb && wb_we)
            imem[wb_adr] <= wb_dat_w;
    end

    // ack only answers a request held by the master
    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb) && wb_cyc && wb_stb);

endmodule

//--- hdl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit
    import rv_pkg::*;
(
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    input  logic [2:0]      funct3,
    input  logic            is_branch,
    input  logic            is_jal,
    output logic            taken,
    output logic [XLEN-1:0] target
);

    logic eq;
    logic lt;
    logic cond;

    assign eq = op_a == op_b;
    assign lt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt;
            F3_BGE:  cond = !lt;
            default: cond = 1'b0;
        endcase
    end

    // jal always redirects
    assign taken  = is_jal || (is_branch && cond);
    assign target = pc + imm;

endmodule

//--- hdl/alu_unit.sv
`timescale 1ns/1ns

module alu_unit
    import rv_pkg::*;
(
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    input  alu_op_t         alu_op,
    output logic [XLEN-1:0] result
);

    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            // signed compare, 0 or 1
            ALU_SLT:    result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLL:    result = op_a << shamt;
            ALU_SRL:    result = op_a >> shamt;
            // lui, upper immediate straight through
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

endmodule

//--- hdl/id_ex_if.sv
`timescale 1ns/1ns

// decoded instruction, decode -> execute
interface id_ex_if
    import rv_pkg::*;
();
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rs1_idx;
    logic [REG_AW-1:0] rs2_idx;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   imm;
    logic [REG_AW-1:0] rd;
    logic              reg_write;
    logic              use_imm;
    alu_op_t           alu_op;
    logic              is_branch;
    logic              is_jal;
    logic [2:0]        funct3;

    modport producer (
        output valid, pc, rs1_idx, rs2_idx, rs1_val, rs2_val, imm, rd,
               reg_write, use_imm, alu_op, is_branch, is_jal, funct3
    );

    modport consumer (
        input valid, pc, rs1_idx, rs2_idx, rs1_val, rs2_val, imm, rd,
              reg_write, use_imm, alu_op, is_branch, is_jal, funct3
    );
endinterface

//--- hdl/rv_pkg.sv
package rv_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int XLEN    = 32;
    localparam int REG_AW  = 5;
    // word address into the instruction memory
    localparam int IMEM_AW = 10;

    // ------------------------------------------------------------------
    // opcodes of the supported subset
    // ------------------------------------------------------------------
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // funct3 for alu ops, shared by register and immediate forms
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // alu operation select
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    // ------------------------------------------------------------------
    // instruction word, register view and immediate view
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    // hi_imm is imm[11:0] for I, {imm[12|10:5], rs2} for B
    typedef struct packed {
        logic [11:0]       hi_imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        lo_imm;
        logic [6:0]        opcode;
    } bi_fmt_t;

    typedef union packed {
        r_fmt_t  r;
        bi_fmt_t bi;
    } instr_u;

endpackage
